// File: verilog/cache_pkg.sv
`default_nettype none

package cache_pkg;

    // Cache geometry
    localparam int INDEX_W   = 8;
    localparam int OFFSET_W  = 4;
    localparam int TAG_W     = 20;
    localparam int NUM_SETS  = 256;
    localparam int NUM_BANKS = 4;     // Words per line
    localparam int LINE_W    = 128;

    typedef logic [31:0]         word_t;
    typedef logic [INDEX_W-1:0]  index_t;
    typedef logic [TAG_W-1:0]    tag_t;
    typedef logic [OFFSET_W-1:0] offset_t;   // Upper two bits pick the bank
    typedef logic [1:0]          bank_sel_t;
    typedef logic [3:0]          strb_t;
    typedef logic [LINE_W-1:0]   line_t;
    typedef logic [LINE_W/8-1:0] line_strb_t;
    typedef logic [31:0]         addr_t;

    // One-hot controller states
    typedef enum logic [4:0] {
        MAIN_IDLE    = 5'b00001,
        MAIN_LOOKUP  = 5'b00010,
        MAIN_MISS    = 5'b00100,
        MAIN_REPLACE = 5'b01000,
        MAIN_REFILL  = 5'b10000
    } main_state_t;

endpackage

`default_nettype wire

// File: verilog/cache_way_if.sv
`timescale 1ns/100ps
`default_nettype none

interface cache_way_if
    import cache_pkg::*;
();

    // Controller to way
    index_t     index;        // Set for both read and write
    logic       tag_we;       // Also sets the valid bit
    tag_t       tag_wdata;
    line_strb_t bank_we;
    line_t      line_wdata;   // Same word in every bank slot
    logic       dirty_we;
    logic       dirty_wdata;

    // Way to controller, one cycle after index
    logic       valid;
    tag_t       tag;
    logic       dirty;
    line_t      line_rdata;

    modport ctrl (
        output index, tag_we, tag_wdata, bank_we, line_wdata, dirty_we, dirty_wdata,
        input  valid, tag, dirty, line_rdata
    );

    modport way (
        input  index, tag_we, tag_wdata, bank_we, line_wdata, dirty_we, dirty_wdata,
        output valid, tag, dirty, line_rdata
    );

endinterface

`default_nettype wire

// File: verilog/cache_way.sv
`timescale 1ns/100ps
`default_nettype none

module cache_way
    import cache_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    cache_way_if.way  bus
);

    tag_t                tag_mem  [NUM_SETS];
    word_t               bank_mem [NUM_BANKS][NUM_SETS];
    logic [NUM_SETS-1:0] valid_bits;
    logic [NUM_SETS-1:0] dirty_bits;

    // Tag array, read returns the old tag on a same-set write
    always_ff @(posedge clk) begin
        if (bus.tag_we) begin
            tag_mem[bus.index] <= bus.tag_wdata;
        end
        bus.tag <= tag_mem[bus.index];
    end

    // Data banks with byte enables
    always_ff @(posedge clk) begin
        for (int b = 0; b < NUM_BANKS; b++) begin
            for (int i = 0; i < 4; i++) begin
                if (bus.bank_we[b*4 + i]) begin
                    bank_mem[b][bus.index][i*8 +: 8] <= bus.line_wdata[b*32 + i*8 +: 8];
                end
            end
            bus.line_rdata[b*32 +: 32] <= bank_mem[b][bus.index];
        end
    end

    // Valid and dirty flags live in flops so they can be cleared
    always_ff @(posedge clk) begin
        if (reset) begin
            valid_bits <= '0;
            dirty_bits <= '0;
            bus.valid  <= 1'b0;
            bus.dirty  <= 1'b0;
        end
        else begin
            if (bus.tag_we) begin
                valid_bits[bus.index] <= 1'b1;
            end
            if (bus.dirty_we) begin
                dirty_bits[bus.index] <= bus.dirty_wdata;
            end
            bus.valid <= valid_bits[bus.index];
            bus.dirty <= dirty_bits[bus.index];
        end
    end

endmodule

`default_nettype wire

// File: verilog/cache_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module cache_ctrl
    import cache_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    // CPU side
    input  logic       valid,
    input  logic       op,          // 1 for store
    input  index_t     index,
    input  tag_t       tag,
    input  offset_t    offset,
    input  strb_t      wstrb,
    input  word_t      wdata,
    output logic       addr_ok,
    output logic       data_ok,
    output word_t      rdata,
    // Memory side
    output logic       rd_req,
    output addr_t      rd_addr,
    input  logic       rd_rdy,
    input  logic       ret_valid,
    input  logic       ret_last,
    input  word_t      ret_data,
    output logic       wr_req,
    output addr_t      wr_addr,
    output line_t      wr_data,
    input  logic       wr_rdy,
    // Way storage
    cache_way_if.ctrl  way0,
    cache_way_if.ctrl  way1
);

    main_state_t state;
    main_state_t next_state;
    logic        main_idle;
    logic        main_lookup;
    logic        main_miss;
    logic        main_replace;
    logic        main_refill;

    // Request buffer
    logic        rq_op;
    index_t      rq_index;
    tag_t        rq_tag;
    offset_t     rq_offset;
    strb_t       rq_wstrb;
    word_t       rq_wdata;
    logic        rq_victim;      // Way picked for replacement
    bank_sel_t   rq_bank;

    logic [22:0] lfsr;
    bank_sel_t   refill_cnt;

    logic        hit0;
    logic        hit1;
    logic        cache_hit;
    word_t       load_word;

    tag_t        victim_tag;
    line_t       victim_line;
    logic        victim_dirty;

    logic        store_hit;
    logic        refill_beat;
    logic        refill_done;
    word_t       refill_word;
    word_t       wr_word;
    strb_t       wr_strb;
    bank_sel_t   wr_bank;
    line_strb_t  line_strb;

    function automatic word_t merge_word(word_t old_word, word_t new_word, strb_t strb);
        word_t merged;
        merged = old_word;
        for (int i = 0; i < 4; i++) begin
            if (strb[i]) begin
                merged[i*8 +: 8] = new_word[i*8 +: 8];
            end
        end
        return merged;
    endfunction

    assign main_idle    = (state == MAIN_IDLE);
    assign main_lookup  = (state == MAIN_LOOKUP);
    assign main_miss    = (state == MAIN_MISS);
    assign main_replace = (state == MAIN_REPLACE);
    assign main_refill  = (state == MAIN_REFILL);

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= MAIN_IDLE;
        end
        else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            MAIN_IDLE:    if (valid) next_state = MAIN_LOOKUP;
            MAIN_LOOKUP:  next_state = cache_hit ? MAIN_IDLE : MAIN_MISS;
            MAIN_MISS:    if (!victim_dirty || wr_rdy) next_state = MAIN_REPLACE;
            MAIN_REPLACE: if (rd_rdy) next_state = MAIN_REFILL;
            MAIN_REFILL:  if (refill_done) next_state = MAIN_IDLE;
            default:      next_state = MAIN_IDLE;
        endcase
    end

    // One request in flight, accepted only in idle
    assign addr_ok = main_idle && valid;

    always_ff @(posedge clk) begin
        if (addr_ok) begin
            rq_op     <= op;
            rq_index  <= index;
            rq_tag    <= tag;
            rq_offset <= offset;
            rq_wstrb  <= wstrb;
            rq_wdata  <= wdata;
            rq_victim <= lfsr[0];
        end
    end

    assign rq_bank = rq_offset[OFFSET_W-1 -: 2];

    always_ff @(posedge clk) begin
        if (reset) begin
            lfsr <= {7'b1010101, 16'h00FF};
        end
        else begin
            lfsr <= {lfsr[21:0], lfsr[22] ^ lfsr[17]};
        end
    end

    // Tag compare against the buffered request
    assign hit0      = way0.valid && (way0.tag == rq_tag);
    assign hit1      = way1.valid && (way1.tag == rq_tag);
    assign cache_hit = hit0 || hit1;

    assign load_word = hit1 ? way1.line_rdata[{rq_bank, 5'b0} +: 32]
                            : way0.line_rdata[{rq_bank, 5'b0} +: 32];

    // Victim is captured before the refill overwrites it
    always_ff @(posedge clk) begin
        if (main_lookup && !cache_hit) begin
            victim_tag  <= rq_victim ? way1.tag : way0.tag;
            victim_line <= rq_victim ? way1.line_rdata : way0.line_rdata;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            victim_dirty <= 1'b0;
        end
        else if (main_lookup && !cache_hit) begin
            victim_dirty <= rq_victim ? (way1.valid && way1.dirty)
                                      : (way0.valid && way0.dirty);
        end
    end

    assign refill_beat = main_refill && ret_valid;
    assign refill_done = refill_beat && ret_last;

    always_ff @(posedge clk) begin
        if (reset) begin
            refill_cnt <= '0;
        end
        else if (refill_done) begin
            refill_cnt <= '0;
        end
        else if (refill_beat) begin
            refill_cnt <= refill_cnt + 1'b1;
        end
    end

    // CPU responses
    assign data_ok = (main_lookup && cache_hit) || (refill_beat && refill_cnt == rq_bank);
    assign rdata   = main_lookup ? load_word : ret_data;   // Critical word during refill

    // Memory requests
    assign wr_req  = main_miss && victim_dirty;
    assign wr_addr = {victim_tag, rq_index, {OFFSET_W{1'b0}}};
    assign wr_data = victim_line;
    assign rd_req  = main_replace;
    assign rd_addr = {rq_tag, rq_index, {OFFSET_W{1'b0}}};

    // Way writes
    assign store_hit   = main_lookup && cache_hit && rq_op;
    assign refill_word = (rq_op && refill_cnt == rq_bank) ?
                         merge_word(ret_data, rq_wdata, rq_wstrb) : ret_data;
    assign wr_word     = main_refill ? refill_word : rq_wdata;
    assign wr_strb     = main_refill ? '1 : rq_wstrb;
    assign wr_bank     = main_refill ? refill_cnt : rq_bank;
    assign line_strb   = line_strb_t'(wr_strb) << {wr_bank, 2'b00};

    assign way0.index       = main_idle ? index : rq_index;
    assign way0.line_wdata  = {NUM_BANKS{wr_word}};
    assign way0.bank_we     = ((store_hit && hit0) || (refill_beat && !rq_victim)) ?
                              line_strb : '0;
    assign way0.tag_we      = refill_done && !rq_victim;
    assign way0.tag_wdata   = rq_tag;
    assign way0.dirty_we    = (store_hit && hit0) || (refill_done && !rq_victim);
    assign way0.dirty_wdata = rq_op;      // High on a store hit, op after refill

    assign way1.index       = main_idle ? index : rq_index;
    assign way1.line_wdata  = {NUM_BANKS{wr_word}};
    assign way1.bank_we     = ((store_hit && hit1) || (refill_beat && rq_victim)) ?
                              line_strb : '0;
    assign way1.tag_we      = refill_done && rq_victim;
    assign way1.tag_wdata   = rq_tag;
    assign way1.dirty_we    = (store_hit && hit1) || (refill_done && rq_victim);
    assign way1.dirty_wdata = rq_op;

endmodule

`default_nettype wire

// File: verilog/cache_top.sv
`timescale 1ns/100ps
`default_nettype none

module cache_top
    import cache_pkg::*;
(
    input  logic    clk,
    input  logic    reset,
    // CPU side
    input  logic    valid,
    input  logic    op,          // 1 for store
    input  index_t  index,
    input  tag_t    tag,
    input  offset_t offset,
    input  strb_t   wstrb,
    input  word_t   wdata,
    output logic    addr_ok,
    output logic    data_ok,
    output word_t   rdata,
    // Memory side
    output logic    rd_req,
    output addr_t   rd_addr,
    input  logic    rd_rdy,
    input  logic    ret_valid,
    input  logic    ret_last,
    input  word_t   ret_data,
    output logic    wr_req,
    output addr_t   wr_addr,
    output line_t   wr_data,
    input  logic    wr_rdy
);

    cache_way_if way_bus0 ();
    cache_way_if way_bus1 ();

    cache_ctrl ctrl (
        .clk       (clk),
        .reset     (reset),
        .valid     (valid),
        .op        (op),
        .index     (index),
        .tag       (tag),
        .offset    (offset),
        .wstrb     (wstrb),
        .wdata     (wdata),
        .addr_ok   (addr_ok),
        .data_ok   (data_ok),
        .rdata     (rdata),
        .rd_req    (rd_req),
        .rd_addr   (rd_addr),
        .rd_rdy    (rd_rdy),
        .ret_valid (ret_valid),
        .ret_last  (ret_last),
        .ret_data  (ret_data),
        .wr_req    (wr_req),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data),
        .wr_rdy    (wr_rdy),
        .way0      (way_bus0),
        .way1      (way_bus1)
    );

    cache_way way0 (
        .clk   (clk),
        .reset (reset),
        .bus   (way_bus0)
    );

    cache_way way1 (
        .clk   (clk),
        .reset (reset),
        .bus   (way_bus1)
    );

endmodule

`default_nettype wire

// File: sim/clk_gen.sv
`timescale 1ns/100ps
`default_nettype none

module clk_gen (
    output logic clk
);

    localparam real HALF_PERIOD = 10.0;   // 20 ns period

    initial begin
        clk = 1'b0;
    end

    always #(HALF_PERIOD) clk = ~clk;

endmodule

`default_nettype wire

// File: sim/mem_model.sv
`timescale 1ns/100ps
`default_nettype none

module mem_model
    import cache_pkg::*;
(
    input  logic  clk,
    input  logic  reset,
    input  logic  rd_req,
    input  addr_t rd_addr,
    output logic  rd_rdy,
    output logic  ret_valid,
    output logic  ret_last,
    output word_t ret_data,
    input  logic  wr_req,
    input  addr_t wr_addr,
    input  line_t wr_data,
    output logic  wr_rdy
);

    localparam int SEED = 32'h4eab9c5a;

    integer seed = SEED;
    line_t  store [addr_t];   // Lines written back, keyed by line address
    line_t  ret_line;
    int     beat;             // Next refill beat, -1 when idle
    int     rd_wait;          // Cycles left before rd_rdy
    int     wr_wait;

    // Initial content mixes every address bit
    function automatic word_t fill_word(addr_t a);
        return (a * 32'h9e3779b1) ^ {a[15:0], a[31:16]};
    endfunction

    function automatic line_t read_line(addr_t a);
        line_t l;
        if (store.exists(a)) begin
            return store[a];
        end
        for (int b = 0; b < NUM_BANKS; b++) begin
            l[b*32 +: 32] = fill_word(a + addr_t'(4*b));
        end
        return l;
    endfunction

    always @(posedge clk) begin
        if (reset) begin
            rd_rdy    <= 1'b0;
            wr_rdy    <= 1'b0;
            ret_valid <= 1'b0;
            ret_last  <= 1'b0;
            ret_data  <= '0;
            beat      = -1;
            rd_wait   = -1;
            wr_wait   = -1;
        end
        else begin
            ret_valid <= 1'b0;
            ret_last  <= 1'b0;
            if (beat >= 0) begin                     // Four beats in bank order
                ret_valid <= 1'b1;
                ret_last  <= (beat == NUM_BANKS - 1);
                ret_data  <= ret_line[beat*32 +: 32];
                beat = (beat == NUM_BANKS - 1) ? -1 : beat + 1;
            end
            if (rd_req && rd_rdy) begin
                rd_rdy   <= 1'b0;
                ret_line = read_line(rd_addr);
                beat     = 0;
            end
            else if (rd_req) begin
                if (rd_wait < 0) begin
                    rd_wait = $unsigned($random(seed)) % 4;
                end
                if (rd_wait == 0) begin
                    rd_rdy <= 1'b1;
                end
                rd_wait = rd_wait - 1;
            end
            if (wr_req && wr_rdy) begin
                wr_rdy         <= 1'b0;
                store[wr_addr] = wr_data;            // Whole line write
            end
            else if (wr_req) begin
                if (wr_wait < 0) begin
                    wr_wait = $unsigned($random(seed)) % 4;
                end
                if (wr_wait == 0) begin
                    wr_rdy <= 1'b1;
                end
                wr_wait = wr_wait - 1;
            end
        end
    end

endmodule

`default_nettype wire

// File: sim/tb_cache.sv
`timescale 1ns/100ps
`default_nettype none

module tb_cache
    import cache_pkg::*;
();

    localparam int SEED       = 32'h4eab9c5a;
    localparam int TIMEOUT    = 200;   // Cycles allowed for any single wait
    localparam int NUM_RANDOM = 400;

    logic    clk;
    logic    reset;
    logic    valid;
    logic    op;
    index_t  index;
    tag_t    tag;
    offset_t offset;
    strb_t   wstrb;
    word_t   wdata;
    logic    addr_ok;
    logic    data_ok;
    word_t   rdata;
    logic    rd_req;
    addr_t   rd_addr;
    logic    rd_rdy;
    logic    ret_valid;
    logic    ret_last;
    word_t   ret_data;
    logic    wr_req;
    addr_t   wr_addr;
    line_t   wr_data;
    logic    wr_rdy;

    integer  seed = SEED;
    int      errors = 0;
    int      timeouts = 0;
    int      accesses = 0;
    word_t   shadow [addr_t];        // CPU view of memory, keyed by word address
    bit      dirty_lines [addr_t];   // Lines stored to since their fill

    // Expectations for the request in flight
    logic    cur_op = 1'b0;
    addr_t   cur_line = '0;
    word_t   exp_rdata = '0;
    logic    same_line = 1'b0;       // Same line as the previous access, so a hit
    addr_t   prev_line = '1;
    line_t   exp_wr_line = '0;
    logic    wr_in_dirty = 1'b0;

    clk_gen clock (.clk(clk));

    cache_top UUT (.*);

    mem_model mem (.*);

    function automatic word_t fill_word(addr_t a);
        return (a * 32'h9e3779b1) ^ {a[15:0], a[31:16]};
    endfunction

    function automatic word_t shadow_word(addr_t a);
        return shadow.exists(a) ? shadow[a] : fill_word(a);
    endfunction

    function automatic line_t shadow_line(addr_t a);
        line_t l;
        for (int b = 0; b < NUM_BANKS; b++) begin
            l[b*32 +: 32] = shadow_word(a + addr_t'(4*b));
        end
        return l;
    endfunction

    function automatic word_t apply_strobes(word_t old_word, word_t new_word, strb_t strb);
        word_t mask;
        mask = {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
        return (old_word & ~mask) | (new_word & mask);
    endfunction

    function automatic addr_t make_addr(tag_t t, index_t i, bank_sel_t b);
        return {t, i, b, 2'b00};
    endfunction

    function automatic int rand_below(int n);
        return $unsigned($random(seed)) % n;
    endfunction

    task automatic report_and_finish();
        $display("Summary: %0d accesses, %0d errors, %0d timeouts", accesses, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("test passed");
        end
        else begin
            $display("test failed");
        end
        $finish;
    endtask

    // One load or store, from request to data_ok
    task automatic access(input logic is_store, input addr_t addr, input strb_t strb,
                          input word_t data);
        addr_t word_addr;
        addr_t line_addr;
        int    n;
        word_addr = {addr[31:2], 2'b00};
        line_addr = {addr[31:4], 4'h0};
        @(posedge clk);
        valid     <= 1'b1;
        op        <= is_store;
        tag       <= addr[31:12];
        index     <= addr[11:4];
        offset    <= addr[3:0];
        wstrb     <= strb;
        wdata     <= data;
        cur_op    <= is_store;
        cur_line  <= line_addr;
        exp_rdata <= shadow_word(word_addr);
        same_line <= (line_addr == prev_line);
        n = 0;
        @(negedge clk);
        while (!addr_ok && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (!addr_ok) begin
            $display("Timeout at %0t, request to %h never accepted", $time, addr);
            timeouts++;
            report_and_finish();
        end
        @(posedge clk);                 // Acceptance edge
        valid <= 1'b0;
        n = 0;
        @(negedge clk);
        while (!data_ok && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (!data_ok) begin
            $display("Timeout at %0t, no data_ok for request to %h", $time, addr);
            timeouts++;
            report_and_finish();
        end
        if (is_store) begin
            shadow[word_addr]      = apply_strobes(shadow_word(word_addr), data, strb);
            dirty_lines[line_addr] = 1'b1;
        end
        prev_line = line_addr;
        accesses++;
    endtask

    // Write-back expectations, settled before the edge that transfers the line
    always @(negedge clk) begin
        if (wr_req) begin
            wr_in_dirty = (dirty_lines.exists(wr_addr) != 0);
            exp_wr_line = shadow_line(wr_addr);
            if (wr_rdy) begin
                dirty_lines.delete(wr_addr);
            end
        end
    end

    assert property (@(posedge clk) $past(reset) |-> !(data_ok || rd_req || wr_req))
        else begin
            errors++;
            $display("ERROR %0t data_ok/rd_req/wr_req got %b expected 000",
                     $time, $sampled({data_ok, rd_req, wr_req}));
        end

    // Only one request in flight, so no acceptance in the lookup cycle
    assert property (@(posedge clk) disable iff (reset) (valid && addr_ok) |=> !addr_ok)
        else begin
            errors++;
            $display("ERROR %0t addr_ok got 1 expected 0 right after acceptance", $time);
        end

    assert property (@(posedge clk) disable iff (reset)
                     (data_ok && !cur_op) |-> rdata == exp_rdata)
        else begin
            errors++;
            $display("ERROR %0t rdata got %h expected %h",
                     $time, $sampled(rdata), $sampled(exp_rdata));
        end

    assert property (@(posedge clk) disable iff (reset)
                     (valid && addr_ok && same_line) |=> data_ok)
        else begin
            errors++;
            $display("ERROR %0t data_ok got 0 expected 1 one cycle after a hit", $time);
        end

    assert property (@(posedge clk) disable iff (reset) rd_req |-> !same_line)
        else begin
            errors++;
            $display("Refill of line %h at %0t right after an access to it",
                     $sampled(rd_addr), $time);
        end

    assert property (@(posedge clk) disable iff (reset) rd_req |-> rd_addr == cur_line)
        else begin
            errors++;
            $display("ERROR %0t rd_addr got %h expected %h",
                     $time, $sampled(rd_addr), $sampled(cur_line));
        end

    assert property (@(posedge clk) disable iff (reset) (wr_req && wr_rdy) |-> wr_in_dirty)
        else begin
            errors++;
            $display("Write-back at %0t of line %h that was not stored to since its fill",
                     $time, $sampled(wr_addr));
        end

    assert property (@(posedge clk) disable iff (reset)
                     (wr_req && wr_rdy) |-> wr_data == exp_wr_line)
        else begin
            errors++;
            $display("ERROR %0t wr_data got %h expected %h",
                     $time, $sampled(wr_data), $sampled(exp_wr_line));
        end

    assert property (@(posedge clk) disable iff (reset)
                     (rd_req && !rd_rdy) |=> (rd_req && $stable(rd_addr)))
        else begin
            errors++;
            $display("Read request dropped or moved at %0t before rd_rdy", $time);
        end

    assert property (@(posedge clk) disable iff (reset)
                     (wr_req && !wr_rdy) |=> (wr_req && $stable(wr_addr)))
        else begin
            errors++;
            $display("Write request dropped or moved at %0t before wr_rdy", $time);
        end

    initial begin
        addr_t a;
        reset  = 1'b1;
        valid  = 1'b0;
        op     = 1'b0;
        index  = '0;
        tag    = '0;
        offset = '0;
        wstrb  = '0;
        wdata  = '0;
        repeat (5) @(posedge clk);
        reset <= 1'b0;

        // Every strobe pattern, first on a store miss and then on a store hit
        for (int s = 0; s < 16; s++) begin
            a = make_addr(tag_t'(16 + s), index_t'(8 + s), bank_sel_t'(s));
            access(1'b1, a, strb_t'(s), $random(seed));
            access(1'b0, a, '0, '0);
            access(1'b1, a, strb_t'(15 - s), $random(seed));
            access(1'b0, a, '0, '0);
        end

        // Four dirty tags in one set force write-backs
        for (int r = 0; r < 3; r++) begin
            for (int t = 1; t <= 4; t++) begin
                access(1'b1, make_addr(tag_t'(t), 8'h40, bank_sel_t'(r)), 4'hf, $random(seed));
            end
        end
        for (int t = 1; t <= 4; t++) begin
            access(1'b0, make_addr(tag_t'(t), 8'h40, 2'd1), '0, '0);
        end

        // Lines that are only loaded
        for (int r = 0; r < 2; r++) begin
            for (int t = 1; t <= 4; t++) begin
                access(1'b0, make_addr(tag_t'(t), 8'h41, bank_sel_t'(r)), '0, '0);
            end
        end

        // Random mix over a small footprint
        for (int i = 0; i < NUM_RANDOM; i++) begin
            a = make_addr(tag_t'(rand_below(6)), index_t'(rand_below(4)),
                          bank_sel_t'(rand_below(4)));
            access(rand_below(2) == 1, a, strb_t'(rand_below(16)), $random(seed));
        end

        repeat (3) @(posedge clk);
        report_and_finish();
    end

endmodule

`default_nettype wire

// File: cache_top.f
verilog/cache_pkg.sv
verilog/cache_way_if.sv
verilog/cache_way.sv
verilog/cache_ctrl.sv
verilog/cache_top.sv
sim/clk_gen.sv
sim/mem_model.sv
sim/tb_cache.sv

// File: run.sh
#!/bin/sh
# Build and run the cache testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module tb_cache -Mdir obj_dir -f cache_top.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/Vtb_cache)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

printf '%s\n' "$out" | grep -qx "test passed"
if [ $? -ne 0 ]; then
    exit 1
fi
exit 0
